// ==== src.f ====
+incdir+sim
logic/rvDecodePkg.sv
logic/fetchQueue.sv
logic/decodeStage.sv
logic/instrDecoder.sv
logic/immGen.sv
logic/decodeFront.sv
sim/decodeFront_checker.sv
sim/decodeFrontTb.sv

// ==== sim/decodeRefModel.svh ====
`ifndef DECODE_REF_MODEL_SVH
`define DECODE_REF_MODEL_SVH

// Expected decode of one item
typedef struct packed {
	logic [4:0]  rs1;
	logic [4:0]  rs2;
	logic [4:0]  rd;
	logic [2:0]  unit;
	logic [3:0]  aluFn;
	logic [2:0]  mulDivOp;
	logic [3:0]  memOp;
	logic [1:0]  pcSel;
	logic [1:0]  bSel;
	logic        we;
	logic        bType;
	logic        bNeq;
	logic        jmp;
	logic        jr;
	logic        lui;
	logic        auipc;
	logic        ecall;
	logic        illegal;
	logic [31:0] imm;
} expDecode;

// RV32I funct3 table, alt is the funct7 bit 30 variant
function automatic logic [3:0] aluFromFunct(input logic [2:0] f3, input logic alt);
	case (f3)
		3'd0:    return alt ? aluSub : aluAdd;
		3'd1:    return aluSll;
		3'd2:    return aluSlt;
		3'd3:    return aluSltu;
		3'd4:    return aluXor;
		3'd5:    return alt ? aluSra : aluSrl;
		3'd6:    return aluOr;
		default: return aluAnd;
	endcase
endfunction

// Encodings outside RV32IM and outside this front end
function automatic logic predictIllegal(input logic [31:0] w);
	logic [2:0] f3;
	logic [6:0] f7;
	f3 = w[14:12];
	f7 = w[31:25];
	case (w[6:0])
		opLoad:                return (f3 == 3'd3) || (f3 > 3'd5);
		opStore:               return f3 > 3'd2;
		opBranch:              return (f3 == 3'd2) || (f3 == 3'd3);
		opJal, opLui, opAuipc: return 1'b0;
		opJalr:                return f3 != 3'd0;
		opOpImm:               return (f3 == 3'd1 && f7 != 7'h00) ||
			(f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
		opOp:                  return !(f7 == 7'h00 || f7 == 7'h01 ||
			(f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
		opSystem:              return w != 32'h0000_0073; // ECALL only
		default:               return 1'b1;
	endcase
endfunction

function automatic expDecode predictDecode(input logic [31:0] w, input logic mis);
	expDecode    e;
	logic [2:0]  f3;
	logic        wr;
	logic [31:0] immI;
	logic [31:0] immS;
	logic [31:0] immB;
	logic [31:0] immU;
	logic [31:0] immJ;
	f3   = w[14:12];
	// Spec bit layouts
	immI = {{20{w[31]}}, w[31:20]};
	immS = {{20{w[31]}}, w[31:25], w[11:7]};
	immB = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
	immU = {w[31:12], 12'd0};
	immJ = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
	e = '0;
	e.rs1     = w[19:15]; // Raw fields, legal or not
	e.rs2     = w[24:20];
	e.rd      = w[11:7];
	e.unit    = unitAlu;
	e.aluFn   = aluAdd;
	e.memOp   = memNone;
	e.pcSel   = pcNext;
	e.bSel    = bReg;
	e.ecall   = (w == 32'h0000_0073);
	e.illegal = predictIllegal(w);
	wr = 1'b0;
	if (e.illegal)
		e.unit = unitSys; // Trap only
	else
	begin
		case (w[6:0])
			opLoad:
			begin
				e.unit  = unitMem;
				e.memOp = {1'b0, f3[2], f3[1:0] + 2'd1}; // Unsigned bit, size
				e.bSel  = bImm;
				e.imm   = immI;
				wr = 1'b1;
			end
			opStore:
			begin
				e.unit  = unitMem;
				e.memOp = {1'b1, 1'b0, f3[1:0] + 2'd1};
				e.bSel  = bImm;
				e.imm   = immS;
			end
			opBranch:
			begin
				e.unit  = unitBranch;
				e.pcSel = pcBranch;
				e.bType = 1'b1;
				e.bNeq  = f3[0];
				e.aluFn = !f3[2] ? aluSub : (f3[1] ? aluSltu : aluSlt);
				e.imm   = immB;
			end
			opJal:
			begin
				e.unit  = unitBranch;
				e.pcSel = pcJump;
				e.aluFn = aluPassB; // Link value
				e.bSel  = bPc4;
				e.jmp   = 1'b1;
				e.imm   = immJ;
				wr = 1'b1;
			end
			opJalr:
			begin
				e.unit  = unitBranch;
				e.pcSel = pcReg;
				e.aluFn = aluPassB;
				e.bSel  = bPc4;
				e.jr    = 1'b1;
				e.imm   = immI;
				wr = 1'b1;
			end
			opLui:
			begin
				e.aluFn = aluPassB;
				e.bSel  = bImm;
				e.lui   = 1'b1;
				e.imm   = immU;
				wr = 1'b1;
			end
			opAuipc:
			begin
				e.bSel  = bImm;
				e.auipc = 1'b1;
				e.imm   = immU;
				wr = 1'b1;
			end
			opOpImm:
			begin
				e.bSel  = bImm;
				e.aluFn = aluFromFunct(f3, (f3 == 3'd5) && w[30]); // srai only
				e.imm   = immI;
				wr = 1'b1;
			end
			opOp:
			begin
				if (w[31:25] == 7'h01)
				begin
					e.unit     = unitMulDiv;
					e.mulDivOp = f3;
				end
				else
					e.aluFn = aluFromFunct(f3, w[30]);
				wr = 1'b1;
			end
			default:
				e.unit = unitSys; // ECALL
		endcase
	end
	e.we = wr && !mis && (e.rd != 5'd0);
	return e;
endfunction

`endif

// ==== sim/decodeFrontTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module decodeFrontTb;

	import rvDecodePkg::*;

	localparam int          QueueDepth    = 2;
	localparam int          ClkPeriod     = 4;
	localparam int          AcceptTimeout = 200; // Cycles to get one item in
	localparam int          DrainTimeout  = 100;
	localparam logic [31:0] Seed          = 32'he8ff_0da1;

	`include "decodeRefModel.svh"

	logic        clk;
	logic        nrst;
	logic        flush;
	logic        inValid;
	logic        inReady;
	logic [31:0] inPc;
	logic [31:0] inInstr;
	logic        inMisaligned;
	logic        outValid;
	logic        outReady;
	logic [31:0] outPc;
	logic        outMisaligned;
	logic [4:0]  rs1;
	logic [4:0]  rs2;
	logic [4:0]  rd;
	logic [2:0]  unit;
	logic [3:0]  aluFn;
	logic [2:0]  mulDivOp;
	logic [3:0]  memOp;
	logic [1:0]  pcSel;
	logic [1:0]  bSel;
	logic        we;
	logic        bType;
	logic        bNeq;
	logic        jmp;
	logic        jr;
	logic        lui;
	logic        auipc;
	logic        ecall;
	logic        illegal;
	logic [31:0] imm;

	logic [64:0] expQ [$]; // {misaligned, pc, word} in acceptance order
	string       curTest;
	int          errors;
	int          checks;
	int          tests;
	int          errStart;
	int          checkStart;
	int          outCount; // Outputs consumed so far
	logic [31:0] lastOutPc;

	decodeFront #(.QueueDepth(QueueDepth)) i_decodeFront (
		.clk(clk), .nrst(nrst), .flush(flush),
		.inValid(inValid), .inReady(inReady), .inPc(inPc), .inInstr(inInstr),
		.inMisaligned(inMisaligned), .outValid(outValid), .outReady(outReady),
		.outPc(outPc), .outMisaligned(outMisaligned), .rs1(rs1), .rs2(rs2), .rd(rd),
		.unit(unit), .aluFn(aluFn), .mulDivOp(mulDivOp), .memOp(memOp),
		.pcSel(pcSel), .bSel(bSel), .we(we), .bType(bType), .bNeq(bNeq),
		.jmp(jmp), .jr(jr), .lui(lui), .auipc(auipc), .ecall(ecall),
		.illegal(illegal), .imm(imm)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(ClkPeriod / 2) clk = ~clk;
	end

	task automatic checkValue(input string field, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual)
		begin
			errors++;
			$display("Mismatch in %s, %s: expected %h, actual %h", curTest, field, expected,
				actual);
		end
	endtask

	task automatic startTest(input string name);
		curTest    = name;
		errStart   = errors;
		checkStart = checks;
	endtask

	task automatic finishTest();
		tests++;
		$display("%s: %0d checks, %0d errors", curTest, checks - checkStart, errors - errStart);
	endtask

	// Legal RV32IM templates with random fields or raw junk words
	function automatic logic [31:0] randomInstr(input bit junk);
		logic [4:0]  dst;
		logic [4:0]  src1;
		logic [4:0]  src2;
		logic [2:0]  f3;
		logic [11:0] i12;
		int          kind;
		dst  = 5'($urandom);
		src1 = 5'($urandom);
		src2 = 5'($urandom);
		f3   = 3'($urandom);
		i12  = 12'($urandom);
		kind = junk ? $urandom_range(14) : $urandom_range(11);
		case (kind)
			0:
			begin
				f3 = 3'($urandom_range(4));
				if (f3 > 3'd2)
					f3 = f3 + 3'd1; // Skip funct3 3
				return {i12, src1, f3, dst, opLoad};
			end
			1:
				return {i12[11:5], src2, src1, 3'($urandom_range(2)), i12[4:0], opStore};
			2:
			begin
				f3 = 3'($urandom_range(5));
				if (f3 > 3'd1)
					f3 = f3 + 3'd2; // No funct3 2 or 3
				return {i12[11:5], src2, src1, f3, i12[4:0], opBranch};
			end
			3:  return {20'($urandom), dst, opJal};
			4:  return {i12, src1, 3'b000, dst, opJalr};
			5:  return {20'($urandom), dst, opLui};
			6:  return {20'($urandom), dst, opAuipc};
			7:
			begin
				if (f3 == 3'd1)
					return {7'h00, src2, src1, f3, dst, opOpImm};
				if (f3 == 3'd5)
					return {($urandom_range(1) ? 7'h20 : 7'h00), src2, src1, f3, dst, opOpImm};
				return {i12, src1, f3, dst, opOpImm};
			end
			8:  return {7'h00, src2, src1, f3, dst, opOp};
			9:  return {7'h20, src2, src1, ($urandom_range(1) ? 3'd5 : 3'd0), dst, opOp};
			10: return {7'h01, src2, src1, f3, dst, opOp}; // M extension
			11: return 32'h0000_0073;
			default: return $urandom;
		endcase
	endfunction

	// Compare one consumed result with the model
	task automatic checkOutput();
		logic [64:0] item;
		expDecode    e;
		if (expQ.size() == 0)
		begin
			errors++;
			$display("Unexpected output in %s at pc %h with nothing pending", curTest, outPc);
		end
		else
		begin
			item = expQ.pop_front();
			e = predictDecode(item[31:0], item[64]);
			checkValue("outPc", item[63:32], outPc);
			checkValue("outMisaligned", item[64], outMisaligned);
			checkValue("rs1", e.rs1, rs1);
			checkValue("rs2", e.rs2, rs2);
			checkValue("rd", e.rd, rd);
			checkValue("unit", e.unit, unit);
			checkValue("aluFn", e.aluFn, aluFn);
			checkValue("mulDivOp", e.mulDivOp, mulDivOp);
			checkValue("memOp", e.memOp, memOp);
			checkValue("pcSel", e.pcSel, pcSel);
			checkValue("bSel", e.bSel, bSel);
			checkValue("we", e.we, we);
			checkValue("bType", e.bType, bType);
			checkValue("bNeq", e.bNeq, bNeq);
			checkValue("jmp", e.jmp, jmp);
			checkValue("jr", e.jr, jr);
			checkValue("lui", e.lui, lui);
			checkValue("auipc", e.auipc, auipc);
			checkValue("ecall", e.ecall, ecall);
			checkValue("illegal", e.illegal, illegal);
			checkValue("imm", e.imm, imm);
		end
		outCount++;
		lastOutPc = outPc;
	endtask

	// Drive on the falling edge, then look at what the next rising edge will take
	task automatic runCycle(input logic v, input logic [31:0] pc, input logic [31:0] w,
		input logic mis, input logic rdy, input logic fl, output logic accepted);
		@(negedge clk);
		inValid      = v;
		inPc         = pc;
		inInstr      = w;
		inMisaligned = mis;
		outReady     = rdy;
		flush        = fl;
		#1;
		accepted = inValid && inReady && !flush;
		if (outValid && outReady)
			checkOutput();
		if (flush)
			expQ.delete(); // Whole pipe dropped
		if (accepted)
			expQ.push_back({mis, pc, w});
	endtask

	task automatic sendItem(input logic [31:0] pc, input logic [31:0] w, input logic mis,
		input int readyPct);
		logic acc;
		int   waitCycles;
		acc = 1'b0;
		waitCycles = 0;
		while (!acc && waitCycles < AcceptTimeout)
		begin
			runCycle($urandom_range(99) < 75, pc, w, mis, $urandom_range(99) < readyPct,
				1'b0, acc);
			waitCycles++;
		end
		if (!acc)
		begin
			errors++;
			$display("Timeout in %s: input not accepted within %0d cycles", curTest, waitCycles);
		end
	endtask

	task automatic drain();
		logic acc;
		int   waitCycles;
		waitCycles = 0;
		while ((expQ.size() != 0 || outValid) && waitCycles < DrainTimeout)
		begin
			runCycle(1'b0, 32'd0, 32'd0, 1'b0, 1'b1, 1'b0, acc);
			waitCycles++;
		end
		if (expQ.size() != 0)
		begin
			errors++;
			$display("Timeout in %s: %0d accepted items never came out", curTest, expQ.size());
			expQ.delete();
		end
	endtask

	task automatic testReset();
		startTest("resetState");
		@(negedge clk);
		#1;
		checkValue("outValid", 1'b0, outValid);
		checkValue("inReady", 1'b1, inReady);
		finishTest();
	endtask

	task automatic testStream(input string name, input int count, input bit junk,
		input int readyPct);
		logic [31:0] w;
		logic        mis;
		startTest(name);
		for (int n = 0; n < count; n++)
		begin
			w   = randomInstr(junk);
			mis = ($urandom_range(99) < 5);
			sendItem($urandom, w, mis, readyPct);
		end
		drain();
		finishTest();
	endtask

	task automatic testFlush();
		logic        acc;
		logic [31:0] w;
		int          accepted;
		int          waitCycles;
		int          outBase;
		startTest("flushDrop");
		accepted = 0;
		waitCycles = 0;
		w = randomInstr(1'b0);
		// Stall the issue side until queue and stage are full
		while (accepted < QueueDepth + 1 && waitCycles < AcceptTimeout)
		begin
			runCycle(1'b1, 32'h0000_1000 + 32'(accepted) * 4, w, 1'b0, 1'b0, 1'b0, acc);
			if (acc)
			begin
				accepted++;
				w = randomInstr(1'b0);
			end
			waitCycles++;
		end
		if (accepted < QueueDepth + 1)
		begin
			errors++;
			$display("Timeout in %s: pipe did not fill", curTest);
		end
		outBase = outCount;
		runCycle(1'b1, 32'h0000_2000, w, 1'b0, 1'b0, 1'b1, acc); // Offered on the flush edge
		checkValue("inReady on flush", 1'b1, inReady);
		runCycle(1'b0, 32'd0, 32'd0, 1'b0, 1'b1, 1'b0, acc);
		checkValue("outValid after flush", 1'b0, outValid);
		sendItem(32'h0000_3000, randomInstr(1'b0), 1'b0, 100);
		drain();
		checkValue("outputs after flush", 1, outCount - outBase);
		checkValue("first pc after flush", 32'h0000_3000, lastOutPc);
		finishTest();
	endtask

	initial
	begin
		void'($urandom(Seed));
		errors       = 0;
		checks       = 0;
		tests        = 0;
		outCount     = 0;
		lastOutPc    = 32'd0;
		nrst         = 1'b0;
		flush        = 1'b0;
		inValid      = 1'b0;
		inPc         = 32'd0;
		inInstr      = 32'd0;
		inMisaligned = 1'b0;
		outReady     = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;
		testReset();
		testStream("legalStream", 300, 1'b0, 70);
		testStream("mixedStream", 300, 1'b1, 50);
		testFlush();
		if (i_decodeFront.i_decodeFrontChecker.assertFails != 0)
		begin
			$display("Checker assertions failed %0d times",
				i_decodeFront.i_decodeFrontChecker.assertFails);
			errors += i_decodeFront.i_decodeFrontChecker.assertFails;
		end
		$display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/decodeFront_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module decodeFront_checker (
	input logic        clk,
	input logic        nrst,
	input logic        flush,
	input logic        inValid,
	input logic        inReady,
	input logic        qValid,
	input logic        qReady,
	input logic        outValid,
	input logic        outReady,
	input logic [31:0] outPc,
	input logic        outMisaligned,
	input logic [2:0]  unit,
	input logic [3:0]  aluFn,
	input logic [3:0]  memOp,
	input logic        we,
	input logic        illegal,
	input logic [31:0] imm
);

	int assertFails = 0; // Failed assertion count

	// inReady drops only after a push with no pop
	assert property (@(posedge clk) disable iff (!nrst)
		$fell(inReady) |-> $past(inValid && inReady && !flush && !(qValid && qReady)))
	else
	begin
		assertFails++;
		$error("inReady fell while the queue was not filling");
	end

	// Stalled result holds until taken
	assert property (@(posedge clk) disable iff (!nrst)
		outValid && !outReady && !flush |=>
			outValid && $stable({outPc, outMisaligned, unit, aluFn, memOp, we, illegal, imm}))
	else
	begin
		assertFails++;
		$error("Output changed while stalled");
	end

	assert property (@(posedge clk) disable iff (!nrst) flush |=> !outValid)
	else
	begin
		assertFails++;
		$error("outValid high after flush");
	end

	assert property (@(posedge clk) $rose(nrst) |-> !outValid && inReady)
	else
	begin
		assertFails++;
		$error("Wrong handshake state out of reset");
	end

endmodule

bind decodeFront decodeFront_checker i_decodeFrontChecker (
	.clk(clk), .nrst(nrst), .flush(flush), .inValid(inValid), .inReady(inReady),
	.qValid(qValid), .qReady(qReady), .outValid(outValid), .outReady(outReady),
	.outPc(outPc), .outMisaligned(outMisaligned), .unit(unit), .aluFn(aluFn),
	.memOp(memOp), .we(we), .illegal(illegal), .imm(imm)
);

`default_nettype wire

// ==== logic/decodeFront.sv ====
`timescale 1ns/100ps
`default_nettype none

module decodeFront #(
	parameter int QueueDepth = 2
) (
	input  logic        clk,
	input  logic        nrst,
	input  logic        flush,
	// Fetch side
	input  logic        inValid,
	output logic        inReady,
	input  logic [31:0] inPc,
	input  logic [31:0] inInstr,
	input  logic        inMisaligned,
	// Issue side
	output logic        outValid,
	input  logic        outReady,
	output logic [31:0] outPc,
	output logic        outMisaligned,
	output logic [4:0]  rs1,
	output logic [4:0]  rs2,
	output logic [4:0]  rd,
	output logic [2:0]  unit,
	output logic [3:0]  aluFn,
	output logic [2:0]  mulDivOp,
	output logic [3:0]  memOp,
	output logic [1:0]  pcSel,
	output logic [1:0]  bSel,
	output logic        we,
	output logic        bType,
	output logic        bNeq,
	output logic        jmp,
	output logic        jr,
	output logic        lui,
	output logic        auipc,
	output logic        ecall,
	output logic        illegal,
	output logic [31:0] imm
);

	import rvDecodePkg::*;

	// Queue head
	logic        qValid;
	logic        qReady;
	logic [31:0] qPc;
	logic [31:0] qInstr;
	logic        qMisaligned;

	instrWord    stInstr; // Registered word
	logic [2:0]  immFmt;

	fetchQueue #(.QueueDepth(QueueDepth)) i_fetchQueue (
		.clk(clk), .nrst(nrst), .flush(flush),
		.inValid(inValid), .inReady(inReady), .inPc(inPc),
		.inInstr(inInstr), .inMisaligned(inMisaligned),
		.qValid(qValid), .qReady(qReady), .qPc(qPc),
		.qInstr(qInstr), .qMisaligned(qMisaligned)
	);

	decodeStage i_decodeStage (
		.clk(clk), .nrst(nrst), .flush(flush),
		.qValid(qValid), .qReady(qReady), .qPc(qPc),
		.qInstr(qInstr), .qMisaligned(qMisaligned),
		.outReady(outReady), .stValid(outValid), .stInstr(stInstr),
		.stPc(outPc), .stMisaligned(outMisaligned)
	);

	// Decode straight off the register, zero cycles
	instrDecoder i_instrDecoder (
		.instr(stInstr), .misaligned(outMisaligned),
		.rs1(rs1), .rs2(rs2), .rd(rd), .unit(unit), .aluFn(aluFn),
		.mulDivOp(mulDivOp), .memOp(memOp), .pcSel(pcSel), .bSel(bSel),
		.immFmt(immFmt), .we(we), .bType(bType), .bNeq(bNeq),
		.jmp(jmp), .jr(jr), .lui(lui), .auipc(auipc),
		.ecall(ecall), .illegal(illegal)
	);

	immGen i_immGen (
		.instr(stInstr),
		.immFmt(immFmt), // Chosen by the decoder
		.imm(imm)
	);

endmodule

`default_nettype wire

// ==== logic/immGen.sv ====
`timescale 1ns/100ps
`default_nettype none

module immGen (
	input  rvDecodePkg::instrWord instr,
	input  logic [2:0]            immFmt,
	output logic [31:0]           imm
);

	import rvDecodePkg::*;

	always_comb
	begin
		case (immFmt)
			fmtNone: imm = 32'd0;
			fmtI:
				imm = {{20{instr.i.imm[11]}}, instr.i.imm}; // Loads, jalr, OP-IMM
			fmtS:
				imm = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
			fmtB:
				// Halfword offset, bit zero always clear
				imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
					instr.b.imm10to5, instr.b.imm4to1, 1'b0};
			fmtU:
				imm = {instr.u.imm, 12'd0}; // Upper 20 bits, no extension needed
			fmtJ:
				imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19to12,
					instr.j.imm11, instr.j.imm10to1, 1'b0};
			default: imm = 32'd0; // Unused codes
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/instrDecoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module instrDecoder (
	input  rvDecodePkg::instrWord instr,
	input  logic                  misaligned,
	output logic [4:0]            rs1,
	output logic [4:0]            rs2,
	output logic [4:0]            rd,
	output logic [2:0]            unit,
	output logic [3:0]            aluFn,
	output logic [2:0]            mulDivOp,
	output logic [3:0]            memOp,
	output logic [1:0]            pcSel,
	output logic [1:0]            bSel,
	output logic [2:0]            immFmt,
	output logic                  we,
	output logic                  bType,
	output logic                  bNeq,
	output logic                  jmp,
	output logic                  jr,
	output logic                  lui,
	output logic                  auipc,
	output logic                  ecall,
	output logic                  illegal
);

	import rvDecodePkg::*;

	logic wrRd; // Format writes rd

	// Shared funct3 map of OP and OP-IMM, funct7 checked by caller
	function automatic logic [3:0] baseAlu(input logic [2:0] f3);
		case (f3)
			3'b000:  return aluAdd;
			3'b001:  return aluSll;
			3'b010:  return aluSlt;
			3'b011:  return aluSltu;
			3'b100:  return aluXor;
			3'b101:  return aluSrl;
			3'b110:  return aluOr;
			default: return aluAnd;
		endcase
	endfunction

	assign rs1   = instr.r.rs1;
	assign rs2   = instr.r.rs2;
	assign rd    = instr.r.rd;
	assign ecall = (instr == ecallInstr);

	always_comb
	begin
		unit     = unitAlu;
		aluFn    = aluAdd;
		mulDivOp = 3'd0;
		memOp    = memNone;
		pcSel    = pcNext;
		bSel     = bReg;
		immFmt   = fmtNone;
		bType    = 1'b0;
		bNeq     = 1'b0;
		jmp      = 1'b0;
		jr       = 1'b0;
		lui      = 1'b0;
		auipc    = 1'b0;
		illegal  = 1'b0;
		wrRd     = 1'b0;
		case (instr.r.opcode)
			opLoad:
			begin
				unit   = unitMem; // Address is rs1 + imm
				bSel   = bImm;
				immFmt = fmtI;
				wrRd   = 1'b1;
				case (instr.i.funct3)
					3'b000:  memOp = memLb;
					3'b001:  memOp = memLh;
					3'b010:  memOp = memLw;
					3'b100:  memOp = memLbu;
					3'b101:  memOp = memLhu;
					default: illegal = 1'b1;
				endcase
			end
			opStore:
			begin
				unit   = unitMem;
				bSel   = bImm;
				immFmt = fmtS;
				case (instr.s.funct3)
					3'b000:  memOp = memSb;
					3'b001:  memOp = memSh;
					3'b010:  memOp = memSw;
					default: illegal = 1'b1;
				endcase
			end
			opBranch:
			begin
				unit   = unitBranch;
				pcSel  = pcBranch;
				immFmt = fmtB;
				bType  = 1'b1;
				bNeq   = instr.b.funct3[0]; // Inverts the compare sense
				case (instr.b.funct3[2:1])
					2'b00:   aluFn = aluSub; // beq, bne
					2'b10:   aluFn = aluSlt; // blt, bge
					2'b11:   aluFn = aluSltu; // bltu, bgeu
					default: illegal = 1'b1;
				endcase
			end
			opJal:
			begin
				unit   = unitBranch;
				pcSel  = pcJump;
				aluFn  = aluPassB; // rd gets pc + 4
				bSel   = bPc4;
				immFmt = fmtJ;
				jmp    = 1'b1;
				wrRd   = 1'b1;
			end
			opJalr:
			begin
				unit    = unitBranch;
				pcSel   = pcReg; // Target from rs1 + imm
				aluFn   = aluPassB;
				bSel    = bPc4;
				immFmt  = fmtI;
				jr      = 1'b1;
				wrRd    = 1'b1;
				illegal = (instr.i.funct3 != 3'b000);
			end
			opLui:
			begin
				aluFn  = aluPassB;
				bSel   = bImm;
				immFmt = fmtU;
				lui    = 1'b1;
				wrRd   = 1'b1;
			end
			opAuipc:
			begin
				bSel   = bImm; // Operand A is the pc
				immFmt = fmtU;
				auipc  = 1'b1;
				wrRd   = 1'b1;
			end
			opOpImm:
			begin
				bSel   = bImm;
				immFmt = fmtI;
				wrRd   = 1'b1;
				aluFn  = baseAlu(instr.i.funct3);
				// Shifts reuse the upper imm bits as funct7
				if (instr.i.funct3 == 3'b001)
					illegal = (instr.r.funct7 != 7'b0000000);
				else if (instr.i.funct3 == 3'b101)
				begin
					if (instr.r.funct7 == 7'b0100000)
						aluFn = aluSra;
					else if (instr.r.funct7 != 7'b0000000)
						illegal = 1'b1;
				end
			end
			opOp:
			begin
				wrRd = 1'b1;
				case (instr.r.funct7)
					7'b0000000: aluFn = baseAlu(instr.r.funct3);
					7'b0100000:
					begin
						if (instr.r.funct3 == 3'b000)
							aluFn = aluSub;
						else if (instr.r.funct3 == 3'b101)
							aluFn = aluSra;
						else
							illegal = 1'b1;
					end
					7'b0000001:
					begin
						unit     = unitMulDiv; // M extension
						mulDivOp = instr.r.funct3;
					end
					default: illegal = 1'b1;
				endcase
			end
			opSystem:
			begin
				unit    = unitSys;
				illegal = (instr != ecallInstr); // No CSR or returns here
			end
			default: illegal = 1'b1;
		endcase
		// Illegal word becomes a plain trap request
		if (illegal)
		begin
			unit     = unitSys;
			aluFn    = aluAdd;
			mulDivOp = 3'd0;
			memOp    = memNone;
			pcSel    = pcNext;
			bSel     = bReg;
			immFmt   = fmtNone;
			bType    = 1'b0;
			bNeq     = 1'b0;
			jmp      = 1'b0;
			jr       = 1'b0;
			lui      = 1'b0;
			auipc    = 1'b0;
		end
	end

	// No writeback for x0, traps or fetch faults
	assign we = wrRd && !illegal && !misaligned && (instr.r.rd != 5'd0);

endmodule

`default_nettype wire

// ==== logic/decodeStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module decodeStage (
	input  logic                 clk,
	input  logic                 nrst,
	input  logic                 flush,
	// From fetch queue head
	input  logic                 qValid,
	output logic                 qReady,
	input  logic [31:0]          qPc,
	input  logic [31:0]          qInstr,
	input  logic                 qMisaligned,
	// Issue side back-pressure
	input  logic                 outReady,
	// Registered item
	output logic                 stValid,
	output rvDecodePkg::instrWord stInstr,
	output logic [31:0]          stPc,
	output logic                 stMisaligned
);

	logic load; // Head transfers into the register
	logic consume; // Issue side takes current item

	// Open when empty or draining this cycle
	assign qReady  = !stValid || outReady;
	assign load    = qValid && qReady;
	assign consume = stValid && outReady;

	// Valid bit
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			stValid <= 1'b0;
		else if (flush)
			stValid <= 1'b0; // Kills held item and anything loaded now
		else if (load)
			stValid <= 1'b1;
		else if (consume)
			stValid <= 1'b0; // Taken with nothing behind it
	end

	// Word, pc and flag; held while outReady is low
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			stInstr      <= '0;
			stPc         <= 32'd0;
			stMisaligned <= 1'b0;
		end
		else if (load)
		begin
			stInstr      <= qInstr; // Raw word into union view
			stPc         <= qPc;
			stMisaligned <= qMisaligned;
		end
	end

endmodule

`default_nettype wire

// ==== logic/fetchQueue.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetchQueue #(
	parameter int QueueDepth = 2
) (
	input  logic        clk,
	input  logic        nrst,
	input  logic        flush,
	// Fetch side
	input  logic        inValid,
	output logic        inReady,
	input  logic [31:0] inPc,
	input  logic [31:0] inInstr,
	input  logic        inMisaligned,
	// Head entry to decode stage
	output logic        qValid,
	input  logic        qReady,
	output logic [31:0] qPc,
	output logic [31:0] qInstr,
	output logic        qMisaligned
);

	localparam int PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
	localparam int CntW = $clog2(QueueDepth + 1);

	// Entry storage
	logic [31:0] pcMem [QueueDepth];
	logic [31:0] instrMem [QueueDepth];
	logic        misMem [QueueDepth];

	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [CntW-1:0] count; // Occupied entries
	logic            full;
	logic            push;
	logic            pop;

	// Circular pointer advance
	function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] p);
		if (p == PtrW'(QueueDepth - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign full    = (count == CntW'(QueueDepth));
	assign inReady = !full || flush; // Flush swallows any offered word
	assign qValid  = (count != '0);
	assign push    = inValid && inReady && !flush;
	assign pop     = qValid && qReady;

	// Head entry, no bypass from input
	assign qPc         = pcMem[rdPtr];
	assign qInstr      = instrMem[rdPtr];
	assign qMisaligned = misMem[rdPtr];

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else if (flush)
		begin
			wrPtr <= '0; // Drop everything in flight
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

	// Payload write
	always_ff @(posedge clk)
	begin
		if (push)
		begin
			pcMem[wrPtr]    <= inPc;
			instrMem[wrPtr] <= inInstr;
			misMem[wrPtr]   <= inMisaligned;
		end
	end

endmodule

`default_nettype wire

// ==== logic/rvDecodePkg.sv ====
`default_nettype none

package rvDecodePkg;

	// Major opcodes, RV32IM subset
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal    = 7'b1101111;
	localparam logic [6:0] opJalr   = 7'b1100111;
	localparam logic [6:0] opLui    = 7'b0110111;
	localparam logic [6:0] opAuipc  = 7'b0010111;
	localparam logic [6:0] opOpImm  = 7'b0010011;
	localparam logic [6:0] opOp     = 7'b0110011;
	localparam logic [6:0] opSystem = 7'b1110011;

	localparam logic [31:0] ecallInstr = 32'h0000_0073; // Only legal SYSTEM word

	// Immediate formats
	localparam logic [2:0] fmtNone = 3'd0;
	localparam logic [2:0] fmtI    = 3'd1;
	localparam logic [2:0] fmtS    = 3'd2;
	localparam logic [2:0] fmtB    = 3'd3;
	localparam logic [2:0] fmtU    = 3'd4;
	localparam logic [2:0] fmtJ    = 3'd5;

	// ALU functions
	localparam logic [3:0] aluAdd   = 4'd0;
	localparam logic [3:0] aluSub   = 4'd1;
	localparam logic [3:0] aluSll   = 4'd2;
	localparam logic [3:0] aluSlt   = 4'd3;
	localparam logic [3:0] aluSltu  = 4'd4;
	localparam logic [3:0] aluXor   = 4'd5;
	localparam logic [3:0] aluSrl   = 4'd6;
	localparam logic [3:0] aluSra   = 4'd7;
	localparam logic [3:0] aluOr    = 4'd8;
	localparam logic [3:0] aluAnd   = 4'd9;
	localparam logic [3:0] aluPassB = 4'd10; // Result is operand B

	// Function units
	localparam logic [2:0] unitAlu    = 3'd0;
	localparam logic [2:0] unitMem    = 3'd1;
	localparam logic [2:0] unitMulDiv = 3'd2;
	localparam logic [2:0] unitBranch = 3'd3;
	localparam logic [2:0] unitSys    = 3'd4;

	// Memory op is {store, unsigned, size}; size 01 byte, 10 half, 11 word
	localparam logic [3:0] memNone = 4'b0000;
	localparam logic [3:0] memLb   = 4'b0001;
	localparam logic [3:0] memLh   = 4'b0010;
	localparam logic [3:0] memLw   = 4'b0011;
	localparam logic [3:0] memLbu  = 4'b0101;
	localparam logic [3:0] memLhu  = 4'b0110;
	localparam logic [3:0] memSb   = 4'b1001;
	localparam logic [3:0] memSh   = 4'b1010;
	localparam logic [3:0] memSw   = 4'b1011;

	// Next pc source
	localparam logic [1:0] pcNext   = 2'd0;
	localparam logic [1:0] pcBranch = 2'd1;
	localparam logic [1:0] pcJump   = 2'd2;
	localparam logic [1:0] pcReg    = 2'd3;

	// Operand B source
	localparam logic [1:0] bReg = 2'd0;
	localparam logic [1:0] bImm = 2'd1;
	localparam logic [1:0] bPc4 = 2'd2; // Link value for jumps

	// One instruction word, seen through each base format
	typedef union packed {
		struct packed {logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
			logic [2:0] funct3; logic [4:0] rd; logic [6:0] opcode;} r;
		struct packed {logic [11:0] imm; logic [4:0] rs1;
			logic [2:0] funct3; logic [4:0] rd; logic [6:0] opcode;} i;
		struct packed {logic [6:0] immHi; logic [4:0] rs2; logic [4:0] rs1;
			logic [2:0] funct3; logic [4:0] immLo; logic [6:0] opcode;} s;
		struct packed {logic imm12; logic [5:0] imm10to5; logic [4:0] rs2; logic [4:0] rs1;
			logic [2:0] funct3; logic [3:0] imm4to1; logic imm11; logic [6:0] opcode;} b;
		struct packed {logic [19:0] imm; logic [4:0] rd; logic [6:0] opcode;} u;
		struct packed {logic imm20; logic [9:0] imm10to1; logic imm11; logic [7:0] imm19to12;
			logic [4:0] rd; logic [6:0] opcode;} j;
	} instrWord;

endpackage

`default_nettype wire
